/* files.f */
rtl/uart_pkg.sv
rtl/bram_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/bram_cmd_ctrl.sv
rtl/uart_bram_ctrl.sv
tb/uart_bram_ctrl_assert.sv
tb/tb_uart_bram_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the uart block ram bridge testbench with verilator.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -f files.f --top-module tb_uart_bram_ctrl -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
echo "simulation passed"

/* tb/tb_uart_bram_ctrl.sv */
//**************************************
// testbench for the uart block ram
// bridge: memory model, serial host,
// reply monitor and shadow reference.
//**************************************

module tb_uart_bram_ctrl;

import uart_pkg::*;
import bram_pkg::*;

localparam int CLK_DIV   = 8;
localparam int MEM_AW    = 6;
localparam int MEM_DEPTH = 2 ** MEM_AW;
localparam int N_PART    = 4;
localparam int N_RAND    = 20;

// frames per command, a read counts its reply.
localparam int FRAME_CYC    = 10 * CLK_DIV;
localparam int WR_FRAMES    = 2 + ADDR_BYTES + WORD_BYTES;
localparam int RD_FRAMES    = 1 + ADDR_BYTES + WORD_BYTES;
localparam int TOTAL_FRAMES = 2 + (1 + N_PART + N_RAND) * (WR_FRAMES + RD_FRAMES) + 6 + RD_FRAMES;
localparam int TIMEOUT_CYC  = 2 * TOTAL_FRAMES * FRAME_CYC + 1000;

logic       s_axis;
logic       rst_i;
logic       uart_rx_i;
logic       uart_tx_o;
bram_word_t data_i = '0;
bram_word_t data_o;
bram_addr_t addr_o;
bram_be_t   wr_en_o;

bram_word_t mem [0:MEM_DEPTH-1];
bram_word_t shadow [0:MEM_DEPTH-1];
uart_byte_t mon_q [$];
uart_byte_t exp_q [$];
int         err_data = 0;
int         err_other = 0;
int         bytes_checked = 0;
int         wr_pulses = 0;
int         exp_writes = 0;
bram_addr_t wr_addr_exp = '0;
bram_word_t wr_data_exp = '0;
bram_be_t   wr_be_exp = '0;

uart_bram_ctrl #(
    .CLK_DIV   (CLK_DIV  )
) uart_bram_ctrl_i (
    .s_axis    (s_axis   ),
    .rst_i     (rst_i    ),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o),
    .data_i    (data_i   ),
    .data_o    (data_o   ),
    .addr_o    (addr_o   ),
    .wr_en_o   (wr_en_o  )
);

bind uart_bram_ctrl uart_bram_ctrl_assert i_assert (
    .s_axis     (s_axis   ),
    .rst_i      (rst_i    ),
    .wr_en_i    (wr_en_o  ),
    .uart_tx_i  (uart_tx_o),
    .tx_busy_i  (tx_busy  ),
    .tx_start_i (tx_start )
);

initial begin
    s_axis = 1'b0;
    forever #2 s_axis = ~s_axis;
end

function automatic bram_word_t fill_word(input int idx);
    return bram_word_t'(idx) * 32'h9e37_79b1 ^ 32'h5a5a_0000;
endfunction

// shadow memory, merges writes per lane.
function automatic bram_word_t ref_access(input logic wr, input bram_addr_t addr,
                                          input bram_word_t wdata, input bram_be_t be);
    bram_word_t word;
    word = shadow[addr[MEM_AW-1:0]];
    if (wr) begin
        for (int l = 0; l < WORD_BYTES; l++) begin
            if (be[l]) word[8*l +: 8] = wdata[8*l +: 8];
        end
        shadow[addr[MEM_AW-1:0]] = word;
    end
    return word;
endfunction

//**************************************
// memory model
//**************************************

always @(posedge s_axis) begin
    if (rst_i) begin
        for (int i = 0; i < MEM_DEPTH; i++) mem[i] <= fill_word(i);
        data_i <= '0;
    end else begin
        for (int l = 0; l < WORD_BYTES; l++) begin
            if (wr_en_o[l]) mem[addr_o[MEM_AW-1:0]][8*l +: 8] <= data_o[8*l +: 8];
        end
        data_i <= mem[addr_o[MEM_AW-1:0]]; // one cycle read.
    end
end

// full address, word and mask of the command at the strobe.
always @(posedge s_axis) begin
    if (!rst_i && wr_en_o != '0) begin
        wr_pulses <= wr_pulses + 1;
        if (wr_en_o != wr_be_exp || addr_o != wr_addr_exp || data_o != wr_data_exp) begin
            $display("FAIL %0t: write strobe %h at %h data %h, expected %h at %h data %h",
                     $time, wr_en_o, addr_o, data_o, wr_be_exp, wr_addr_exp, wr_data_exp);
            err_data++;
        end
    end
end

//**************************************
// serial host
//**************************************

task automatic send_byte(input uart_byte_t b, input logic stop_bit);
    logic [UART_DATA_BITS+1:0] frame;
    frame = {stop_bit, b, ~UART_IDLE};
    for (int i = 0; i < UART_DATA_BITS + 2; i++) begin
        @(posedge s_axis);
        uart_rx_i <= frame[i];
        repeat (CLK_DIV - 1) @(posedge s_axis);
    end
endtask

task automatic hold_idle(input int bits);
    for (int i = 0; i < bits * CLK_DIV; i++) begin
        @(posedge s_axis);
        uart_rx_i <= UART_IDLE;
    end
endtask

task automatic send_write(input bram_addr_t addr, input bram_word_t wdata, input bram_be_t be);
    wr_addr_exp = addr;
    wr_data_exp = wdata;
    wr_be_exp   = be;
    send_byte(CMD_WRITE, UART_IDLE);
    for (int i = 0; i < ADDR_BYTES; i++) send_byte(addr[8*i +: 8], UART_IDLE);
    for (int i = 0; i < WORD_BYTES; i++) send_byte(wdata[8*i +: 8], UART_IDLE);
    send_byte(uart_byte_t'(be), UART_IDLE);
    void'(ref_access(1'b1, addr, wdata, be));
    if (be != '0) exp_writes++; // empty mask gives no strobe.
    hold_idle(1);
endtask

task automatic send_read(input bram_addr_t addr);
    bram_word_t want;
    want = ref_access(1'b0, addr, '0, '0);
    for (int i = 0; i < WORD_BYTES; i++) exp_q.push_back(want[8*i +: 8]);
    send_byte(CMD_READ, UART_IDLE);
    for (int i = 0; i < ADDR_BYTES; i++) send_byte(addr[8*i +: 8], UART_IDLE);
    while (exp_q.size() != 0) @(posedge s_axis);
    hold_idle(1);
endtask

task automatic finish_run();
    $display("error count: %0d value mismatches, %0d other failures, %0d reply bytes checked",
             err_data, err_other, bytes_checked);
    if (err_data + err_other == 0) begin
        $display("Finished with no errors");
    end else begin
        $display("Finished with errors");
    end
    $finish;
endtask

//**************************************
// reply monitor and comparison
//**************************************

initial begin : monitor
    uart_byte_t b;
    forever begin
        @(posedge s_axis);
        if (!rst_i && uart_tx_o != UART_IDLE) begin
            repeat (CLK_DIV / 2) @(posedge s_axis);
            if (uart_tx_o != UART_IDLE) begin
                for (int i = 0; i < UART_DATA_BITS; i++) begin
                    repeat (CLK_DIV) @(posedge s_axis);
                    b[i] = uart_tx_o;
                end
                repeat (CLK_DIV) @(posedge s_axis);
                if (uart_tx_o != UART_IDLE) begin
                    $display("reply frame ending at %0t has a low stop bit", $time);
                    err_other++;
                end
                mon_q.push_back(b);
            end
        end
    end
end

initial begin : compare
    uart_byte_t got;
    uart_byte_t want;
    forever begin
        @(posedge s_axis);
        if (mon_q.size() != 0) begin
            got = mon_q.pop_front();
            bytes_checked++;
            if (exp_q.size() == 0) begin
                $display("FAIL %0t: unexpected reply byte %02h", $time, got);
                err_data++;
            end else begin
                want = exp_q.pop_front();
                if (got != want) begin
                    $display("FAIL %0t: reply byte %02h, expected %02h", $time, got, want);
                    err_data++;
                end
            end
        end
    end
end

initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYC) begin
        @(posedge s_axis);
        cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    err_other++;
    finish_run();
end

//**************************************
// stimulus
//**************************************

initial begin : stimulus
    bram_addr_t addr;
    bram_word_t wdata;
    rst_i     = 1'b1;
    uart_rx_i = UART_IDLE;
    void'($urandom(32'ha162_88fe));
    for (int i = 0; i < MEM_DEPTH; i++) shadow[i] = fill_word(i);
    repeat (16) @(posedge s_axis);
    rst_i <= 1'b0;

    // quiet outputs with no input.
    for (int i = 0; i < 20 * CLK_DIV; i++) begin
        @(posedge s_axis);
        if (uart_tx_o != UART_IDLE) begin
            $display("FAIL %0t: serial output low while idle", $time);
            err_data++;
        end
        if (wr_en_o != '0) begin
            $display("FAIL %0t: write strobe %h while idle", $time, wr_en_o);
            err_data++;
        end
    end

    send_write(32'h0000_0004, 32'hdead_beef, 4'hf);
    send_read(32'h0000_0004);

    for (int i = 0; i < N_PART; i++) begin
        wdata = $urandom;
        send_write(32'h0000_0011, wdata, bram_be_t'(4'b0011 << i));
        send_read(32'h0000_0011);
    end

    for (int i = 0; i < N_RAND; i++) begin
        addr  = $urandom;
        wdata = $urandom;
        send_write(addr, wdata, bram_be_t'($urandom));
        if ($urandom % 2 == 0) addr = $urandom;
        send_read(addr);
    end

    // unknown opcodes, then a write cut by a bad stop bit.
    send_byte(8'h3c, UART_IDLE);
    send_byte(8'hff, UART_IDLE);
    hold_idle(2);
    send_byte(CMD_WRITE, UART_IDLE);
    send_byte(8'h04, UART_IDLE);
    send_byte(8'h00, UART_IDLE);
    send_byte(8'h5a, ~UART_IDLE);
    hold_idle(2);
    send_read(32'h0000_0004);

    hold_idle(4);
    if (wr_pulses != exp_writes) begin
        $display("FAIL %0t: %0d write strobes, expected %0d", $time, wr_pulses, exp_writes);
        err_data++;
    end
    if (exp_q.size() != 0 || mon_q.size() != 0) begin
        $display("reply bytes were left over at the end of the run");
        err_other++;
    end
    finish_run();
end

endmodule

/* tb/uart_bram_ctrl_assert.sv */
//**************************************
// bound checks on the bridge: memory
// strobe width and serial line levels.
//**************************************

module uart_bram_ctrl_assert (
    input logic               s_axis,
    input logic               rst_i,
    input bram_pkg::bram_be_t wr_en_i,
    input logic               uart_tx_i,
    input logic               tx_busy_i,
    input logic               tx_start_i
);

wr_en_single: assert property (
    @(posedge s_axis) disable iff (rst_i)
    (wr_en_i != '0) |=> (wr_en_i == '0)
) else $error("write strobe high on two consecutive cycles");

// line register idles high.
tx_idle_high: assert property (
    @(posedge s_axis) disable iff (rst_i)
    !tx_busy_i |-> uart_tx_i
) else $error("serial line low while the transmitter is idle");

tx_start_idle: assert property (
    @(posedge s_axis) disable iff (rst_i)
    tx_start_i |-> !tx_busy_i
) else $error("transmit strobe while the transmitter is busy");

endmodule

/* rtl/uart_bram_ctrl.sv */
//**************************************
// uart to block ram debug bridge: host
// reads and writes memory words through
// a serial command protocol.
//**************************************

module uart_bram_ctrl #(
    parameter int CLK_DIV = 16
) (
    input  logic                 s_axis,
    input  logic                 rst_i,

    input  logic                 uart_rx_i,
    output logic                 uart_tx_o,

    input  bram_pkg::bram_word_t data_i,
    output bram_pkg::bram_word_t data_o,
    output bram_pkg::bram_addr_t addr_o,
    output bram_pkg::bram_be_t   wr_en_o
);

import uart_pkg::*;

uart_byte_t rx_data;
logic       rx_valid;
logic       rx_frame_err;
uart_byte_t tx_data;
logic       tx_start;
logic       tx_busy;

uart_rx #(
    .CLK_DIV        (CLK_DIV     )
) i_uart_rx (
    .s_axis         (s_axis      ),
    .rst_i          (rst_i       ),
    .uart_rx_i      (uart_rx_i   ),
    .rx_data_o      (rx_data     ),
    .rx_valid_o     (rx_valid    ),
    .rx_frame_err_o (rx_frame_err)
);

uart_tx #(
    .CLK_DIV    (CLK_DIV  )
) i_uart_tx (
    .s_axis     (s_axis   ),
    .rst_i      (rst_i    ),
    .tx_data_i  (tx_data  ),
    .tx_start_i (tx_start ),
    .uart_tx_o  (uart_tx_o),
    .tx_busy_o  (tx_busy  )
);

bram_cmd_ctrl i_bram_cmd_ctrl (
    .s_axis         (s_axis      ),
    .rst_i          (rst_i       ),
    .rx_data_i      (rx_data     ),
    .rx_valid_i     (rx_valid    ),
    .rx_frame_err_i (rx_frame_err),
    .tx_busy_i      (tx_busy     ),
    .tx_data_o      (tx_data     ),
    .tx_start_o     (tx_start    ),
    .data_i         (data_i      ),
    .data_o         (data_o      ),
    .addr_o         (addr_o      ),
    .wr_en_o        (wr_en_o     )
);

endmodule

/* rtl/bram_cmd_ctrl.sv */
//**************************************
// command controller: parses read and
// write commands from the uart bytes,
// drives the block ram port and sends
// read data back byte by byte.
//**************************************

module bram_cmd_ctrl (
    input  logic                 s_axis,
    input  logic                 rst_i,
    input  uart_pkg::uart_byte_t rx_data_i,
    input  logic                 rx_valid_i,
    input  logic                 rx_frame_err_i,
    input  logic                 tx_busy_i,
    output uart_pkg::uart_byte_t tx_data_o,
    output logic                 tx_start_o,
    input  bram_pkg::bram_word_t data_i,
    output bram_pkg::bram_word_t data_o,
    output bram_pkg::bram_addr_t addr_o,
    output bram_pkg::bram_be_t   wr_en_o
);

import uart_pkg::*;
import bram_pkg::*;

localparam int BYTE_W = $bits(uart_byte_t);
localparam int ADDR_W = $bits(bram_addr_t);
localparam int WORD_W = $bits(bram_word_t);
localparam int BE_W   = $bits(bram_be_t);

typedef enum logic [2:0] {
    ST_OPCODE     = 3'd0,
    ST_ADDR       = 3'd1,
    ST_DATA       = 3'd2,
    ST_BE         = 3'd3,
    ST_WRITE      = 3'd4,
    ST_RD_WAIT    = 3'd5,
    ST_RD_CAPTURE = 3'd6,
    ST_REPLY      = 3'd7
} state_e;

state_e     state;
logic [2:0] byte_cnt;
logic       is_write;
bram_addr_t addr_q;
bram_word_t data_q;
bram_word_t reply_q;
bram_be_t   wr_en_q;
uart_byte_t tx_data_q;
logic       tx_start_q;
logic       tx_ready;
logic       send_next;

// transmitter idle and no strobe in flight.
assign tx_ready  = !tx_busy_i && !tx_start_q;
assign send_next = (state == ST_REPLY) && tx_ready && (byte_cnt != 3'(WORD_BYTES));

//**************************************
// command fsm
//**************************************

always_ff @(posedge s_axis) begin
    if (rst_i) begin
        state      <= ST_OPCODE;
        byte_cnt   <= '0;
        is_write   <= 1'b0;
        wr_en_q    <= '0;
        tx_start_q <= 1'b0;
    end else begin
        tx_start_q <= 1'b0;
        case (state)
            ST_OPCODE: begin
                byte_cnt <= '0;
                if (rx_valid_i && rx_data_i == CMD_WRITE) begin
                    is_write <= 1'b1;
                    state    <= ST_ADDR;
                end else if (rx_valid_i && rx_data_i == CMD_READ) begin
                    is_write <= 1'b0;
                    state    <= ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (rx_frame_err_i) begin
                    state <= ST_OPCODE;
                end else if (rx_valid_i) begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 3'(ADDR_BYTES - 1)) begin
                        byte_cnt <= '0;
                        state    <= is_write ? ST_DATA : ST_RD_WAIT;
                    end
                end
            end
            ST_DATA: begin
                if (rx_frame_err_i) begin
                    state <= ST_OPCODE;
                end else if (rx_valid_i) begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 3'(WORD_BYTES - 1)) begin
                        state <= ST_BE;
                    end
                end
            end
            ST_BE: begin
                if (rx_frame_err_i) begin
                    state <= ST_OPCODE;
                end else if (rx_valid_i) begin
                    wr_en_q <= rx_data_i[BE_W-1:0];
                    state   <= ST_WRITE;
                end
            end
            ST_WRITE: begin
                wr_en_q <= '0; // single cycle strobe.
                state   <= ST_OPCODE;
            end
            ST_RD_WAIT:    state <= ST_RD_CAPTURE; // ram latency.
            ST_RD_CAPTURE: begin
                tx_start_q <= 1'b1;
                byte_cnt   <= 3'd1;
                state      <= ST_REPLY;
            end
            ST_REPLY: begin
                if (send_next) begin
                    tx_start_q <= 1'b1;
                    byte_cnt   <= byte_cnt + 1'b1;
                end else if (tx_ready) begin
                    state <= ST_OPCODE; // last byte has left.
                end
            end
            default: state <= ST_OPCODE;
        endcase
    end
end

//**************************************
// address, data and reply registers
//**************************************

always_ff @(posedge s_axis) begin
    if (state == ST_ADDR && rx_valid_i) begin
        addr_q <= {rx_data_i, addr_q[ADDR_W-1:BYTE_W]};
    end
    if (state == ST_DATA && rx_valid_i) begin
        data_q <= {rx_data_i, data_q[WORD_W-1:BYTE_W]};
    end
    if (state == ST_RD_CAPTURE) begin
        tx_data_q <= data_i[BYTE_W-1:0];
        reply_q   <= data_i >> BYTE_W;
    end else if (send_next) begin
        tx_data_q <= reply_q[BYTE_W-1:0];
        reply_q   <= reply_q >> BYTE_W;
    end
end

assign addr_o     = addr_q;
assign data_o     = data_q;
assign wr_en_o    = wr_en_q;
assign tx_data_o  = tx_data_q;
assign tx_start_o = tx_start_q;

endmodule

/* rtl/uart_tx.sv */
//**************************************
// uart transmitter: sends one 8N1 frame
// per start strobe, busy until the stop
// bit has been on the line a full period.
//**************************************

module uart_tx #(
    parameter int CLK_DIV = 16
) (
    input  logic                 s_axis,
    input  logic                 rst_i,
    input  uart_pkg::uart_byte_t tx_data_i,
    input  logic                 tx_start_i,
    output logic                 uart_tx_o,
    output logic                 tx_busy_o
);

import uart_pkg::*;

localparam int CNT_W   = $clog2(CLK_DIV);
localparam int FRAME_W = UART_DATA_BITS + 2;
localparam int BIT_W   = $clog2(FRAME_W);

logic [FRAME_W-1:0] frame;
logic [CNT_W-1:0]   cnt;
logic [BIT_W-1:0]   bit_cnt;
logic               bit_tick;

assign bit_tick = (cnt == CNT_W'(CLK_DIV - 1));

//**************************************
// control and line register
//**************************************

always_ff @(posedge s_axis) begin
    if (rst_i) begin
        uart_tx_o <= UART_IDLE;
        tx_busy_o <= 1'b0;
        cnt       <= '0;
        bit_cnt   <= '0;
    end else if (!tx_busy_o) begin
        if (tx_start_i) begin
            uart_tx_o <= ~UART_IDLE; // start bit.
            tx_busy_o <= 1'b1;
            cnt       <= '0;
            bit_cnt   <= '0;
        end
    end else begin
        cnt <= cnt + 1'b1;
        if (bit_tick) begin
            cnt <= '0;
            if (bit_cnt == BIT_W'(FRAME_W - 1)) begin
                uart_tx_o <= UART_IDLE;
                tx_busy_o <= 1'b0; // stop bit done.
            end else begin
                uart_tx_o <= frame[1];
                bit_cnt   <= bit_cnt + 1'b1;
            end
        end
    end
end

//**************************************
// frame shifter
//**************************************

always_ff @(posedge s_axis) begin
    if (!tx_busy_o && tx_start_i) begin
        frame <= {UART_IDLE, tx_data_i, ~UART_IDLE};
    end else if (tx_busy_o && bit_tick) begin
        frame <= {UART_IDLE, frame[FRAME_W-1:1]};
    end
end

endmodule

/* rtl/uart_rx.sv */
//**************************************
// uart receiver: 8N1 frames sampled at
// mid-bit, one pulse per received byte,
// a separate pulse on a low stop bit.
//**************************************

module uart_rx #(
    parameter int CLK_DIV = 16
) (
    input  logic                 s_axis,
    input  logic                 rst_i,
    input  logic                 uart_rx_i,
    output uart_pkg::uart_byte_t rx_data_o,
    output logic                 rx_valid_o,
    output logic                 rx_frame_err_o
);

import uart_pkg::*;

localparam int CNT_W = $clog2(CLK_DIV);
localparam int IDX_W = $clog2(UART_DATA_BITS);

typedef enum logic [1:0] {
    RX_IDLE  = 2'b00,
    RX_START = 2'b01,
    RX_DATA  = 2'b10,
    RX_STOP  = 2'b11
} rx_state_e;

rx_state_e        state;
logic             rx_meta;
logic             rx_sync;
logic [CNT_W-1:0] cnt;
logic [IDX_W-1:0] bit_idx;
logic             half_tick;
logic             bit_tick;

// two flop synchronizer.
always_ff @(posedge s_axis) begin
    if (rst_i) begin
        rx_meta <= UART_IDLE;
        rx_sync <= UART_IDLE;
    end else begin
        rx_meta <= uart_rx_i;
        rx_sync <= rx_meta;
    end
end

assign half_tick = (cnt == CNT_W'(CLK_DIV / 2 - 1));
assign bit_tick  = (cnt == CNT_W'(CLK_DIV - 1));

always_ff @(posedge s_axis) begin
    if (rst_i) begin
        state          <= RX_IDLE;
        cnt            <= '0;
        bit_idx        <= '0;
        rx_valid_o     <= 1'b0;
        rx_frame_err_o <= 1'b0;
    end else begin
        rx_valid_o     <= 1'b0;
        rx_frame_err_o <= 1'b0;
        cnt            <= cnt + 1'b1;
        case (state)
            RX_IDLE: begin
                cnt <= '0;
                if (rx_sync != UART_IDLE) begin
                    state <= RX_START;
                end
            end
            RX_START: begin
                if (half_tick) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    // glitch shorter than half a bit.
                    state   <= (rx_sync != UART_IDLE) ? RX_DATA : RX_IDLE;
                end
            end
            RX_DATA: begin
                if (bit_tick) begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == IDX_W'(UART_DATA_BITS - 1)) begin
                        state <= RX_STOP;
                    end
                end
            end
            RX_STOP: begin
                if (bit_tick) begin
                    rx_valid_o     <= (rx_sync == UART_IDLE);
                    rx_frame_err_o <= (rx_sync != UART_IDLE);
                    state          <= RX_IDLE;
                end
            end
            default: state <= RX_IDLE;
        endcase
    end
end

// lsb arrives first.
always_ff @(posedge s_axis) begin
    if (state == RX_DATA && bit_tick) begin
        rx_data_o <= {rx_sync, rx_data_o[UART_DATA_BITS-1:1]};
    end
end

endmodule

/* rtl/bram_pkg.sv */
//**************************************
// memory side definitions: bus widths of
// the block ram port and the command
// bytes understood by the bridge.
//**************************************

package bram_pkg;

//**************************************
// memory port
//**************************************

// word address, sent lsb first.
typedef logic [31:0] bram_addr_t;

// one memory word, four byte lanes.
typedef logic [31:0] bram_word_t;

// write strobe per byte lane.
typedef logic [3:0]  bram_be_t;

//**************************************
// command protocol
//**************************************

localparam logic [7:0] CMD_WRITE = 8'h57; // 'W'.
localparam logic [7:0] CMD_READ  = 8'h52; // 'R'.

// field lengths in bytes.
localparam int ADDR_BYTES = 4;
localparam int WORD_BYTES = 4;

endpackage

/* rtl/uart_pkg.sv */
//**************************************
// serial line definitions shared by the
// uart receiver, transmitter and the
// command controller.
//**************************************

package uart_pkg;

//**************************************
// data
//**************************************

// one character on the line.
typedef logic [7:0] uart_byte_t;

// bits per frame between start and stop.
localparam int UART_DATA_BITS = 8;

//**************************************
// line levels
//**************************************

localparam logic UART_IDLE = 1'b1; // idle and stop bit.

endpackage
